//--- logic/i3c_pkg.sv
// Shared timing, address, register map and bus structs; one byte per transfer, no I3C extras
package i3c_pkg;

    // clk_i cycles per SCL half period; the target needs at least two samples per phase
    localparam int unsigned SclHalfPeriod = 4;

    // Address of the register target on the shared bus
    localparam logic [6:0] TargetAddr = 7'h2A;

    // Devices on the bus: controller, register target, external pins
    localparam int unsigned NumBusDevices = 3;

    // APB byte offsets
    localparam logic [3:0] RegCtrl   = 4'h0;
    localparam logic [3:0] RegTx     = 4'h4;
    localparam logic [3:0] RegRx     = 4'h8;
    localparam logic [3:0] RegStatus = 4'hC;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [3:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // Command from the register block, start is a single-cycle pulse
    typedef struct packed {
        logic       start;
        logic       rnw;
        logic [6:0] addr;
        logic [7:0] wdata;
    } xfer_cmd_t;

    // Result back to the register block, done pulses as busy falls
    typedef struct packed {
        logic       busy;
        logic       done;
        logic       nack;
        logic [7:0] rdata;
    } xfer_sts_t;

    // Open-drain pair, 1 releases the line and 0 pulls it low
    typedef struct packed {
        logic sda;
        logic scl;
    } od_pins_t;

endpackage

//--- logic/i3c_byte_shifter.sv
// MSB-first 8-bit shifter, load has priority over shift
module i3c_byte_shifter (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       load_i,
    input  logic [7:0] load_data_i,
    input  logic       shift_i,
    input  logic       bit_i,
    output logic       bit_o,
    output logic [7:0] data_o
);

    logic [7:0] data_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            data_q <= '0;
        end else if (load_i) begin
            data_q <= load_data_i;
        end else if (shift_i) begin
            // New bit enters at the LSB
            data_q <= {data_q[6:0], bit_i};
        end
    end

    assign bit_o  = data_q[7];
    assign data_o = data_q;

endmodule

//--- logic/i3c_scl_timer.sv
// Half-period tick generator, first tick a full SclHalfPeriod after enable; needs SclHalfPeriod >= 2
module i3c_scl_timer (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic en_i,
    output logic tick_o
);

    localparam int unsigned CntW = $clog2(i3c_pkg::SclHalfPeriod);
    localparam logic [CntW-1:0] Reload = CntW'(i3c_pkg::SclHalfPeriod - 1);

    logic [CntW-1:0] cnt_q;

    // Held at reload while disabled
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || !en_i) begin
            cnt_q <= Reload;
        end else if (cnt_q == '0) begin
            cnt_q <= Reload;
        end else begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    assign tick_o = en_i && (cnt_q == '0);

endmodule

//--- logic/i3c_bus_harness.sv
// Wired-AND of open-drain drivers, an all-released bus reads high as with a pull-up
module i3c_bus_harness #(
    parameter int unsigned NumDevices = 3
) (
    input  i3c_pkg::od_pins_t dev_i [NumDevices],
    output i3c_pkg::od_pins_t bus_o
);

    always_comb begin
        // Pull-up when nobody drives
        bus_o.sda = 1'b1;
        bus_o.scl = 1'b1;
        for (int i = 0; i < NumDevices; i++) begin
            bus_o.sda = bus_o.sda & dev_i[i].sda;
            bus_o.scl = bus_o.scl & dev_i[i].scl;
        end
    end

endmodule

//--- logic/i3c_apb_regs.sv
// APB register block, no wait states; unmapped offsets and START while busy return pslverr
module i3c_apb_regs (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  i3c_pkg::apb_req_t   apb_req_i,
    output i3c_pkg::apb_rsp_t   apb_rsp_o,
    output i3c_pkg::xfer_cmd_t  cmd_o,
    input  i3c_pkg::xfer_sts_t  sts_i
);

    logic        access;
    logic        mapped;
    logic        start_req;
    logic        err;
    logic        wr_ok;
    logic        rd_status;
    logic [31:0] rdata;
    logic        start_q;
    logic        rnw_q;
    logic [6:0]  addr_q;
    logic [7:0]  tx_q;
    logic [7:0]  rx_q;
    logic        done_q;

    assign access = apb_req_i.psel && apb_req_i.penable;

    // Read mux and offset decode
    always_comb begin
        mapped = 1'b1;
        rdata  = '0;
        case (apb_req_i.paddr)
            i3c_pkg::RegCtrl:   rdata = {23'b0, addr_q, rnw_q, 1'b0};
            i3c_pkg::RegTx:     rdata = {24'b0, tx_q};
            i3c_pkg::RegRx:     rdata = {24'b0, rx_q};
            i3c_pkg::RegStatus: rdata = {29'b0, sts_i.nack, done_q, sts_i.busy};
            default:            mapped = 1'b0;
        endcase
    end

    assign start_req = access && apb_req_i.pwrite && apb_req_i.pwdata[0]
                       && (apb_req_i.paddr == i3c_pkg::RegCtrl);

    assign err = access && (!mapped || (start_req && sts_i.busy));
    assign wr_ok = access && apb_req_i.pwrite && !err;
    assign rd_status = access && !apb_req_i.pwrite && (apb_req_i.paddr == i3c_pkg::RegStatus);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            start_q <= 1'b0;
            rnw_q   <= 1'b0;
            addr_q  <= '0;
            tx_q    <= '0;
            rx_q    <= '0;
            done_q  <= 1'b0;
        end else begin
            start_q <= wr_ok && start_req;
            if (wr_ok && apb_req_i.paddr == i3c_pkg::RegCtrl) begin
                rnw_q  <= apb_req_i.pwdata[1];
                addr_q <= apb_req_i.pwdata[8:2];
            end
            if (wr_ok && apb_req_i.paddr == i3c_pkg::RegTx) begin
                tx_q <= apb_req_i.pwdata[7:0];
            end
            if (sts_i.done) begin
                rx_q <= sts_i.rdata;
            end
            // Sticky done, a new completion wins over a clearing read
            if (sts_i.done) begin
                done_q <= 1'b1;
            end else if (rd_status || (wr_ok && start_req)) begin
                done_q <= 1'b0;
            end
        end
    end

    assign cmd_o.start = start_q;
    assign cmd_o.rnw   = rnw_q;
    assign cmd_o.addr  = addr_q;
    assign cmd_o.wdata = tx_q;

    assign apb_rsp_o.prdata  = rdata;
    assign apb_rsp_o.pready  = 1'b1;
    assign apb_rsp_o.pslverr = err;

    // FSM sees each START request exactly once
    a_start_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        cmd_o.start |=> !cmd_o.start);

endmodule

//--- logic/i3c_bus_fsm.sv
// Bus controller for one address byte and one data byte; no arbitration or clock stretching
module i3c_bus_fsm (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  i3c_pkg::xfer_cmd_t  cmd_i,
    output i3c_pkg::xfer_sts_t  sts_o,
    input  logic                tick_i,
    output logic                timer_en_o,
    input  i3c_pkg::od_pins_t   bus_i,
    output i3c_pkg::od_pins_t   pins_o
);

    typedef enum logic [2:0] {IDLE, START, ADDR, ADDR_ACK, DATA, DATA_ACK, STOP} state_e;

    state_e     state_q;
    logic [2:0] bit_cnt_q;
    logic       fall_q;
    logic       rnw_q;
    logic       nack_q;
    logic       done_q;
    logic       sda_q;
    logic       scl_q;
    logic [7:0] wdata_q;
    logic [7:0] rdata_q;
    logic       sh_load;
    logic       sh_shift;
    logic       sh_bit;
    logic [7:0] sh_load_data;
    logic [7:0] sh_data;

    // Address byte on START, data byte after an ACKed write address
    assign sh_load = (state_q == IDLE && cmd_i.start)
                     || (state_q == ADDR_ACK && tick_i && scl_q && !bus_i.sda && !rnw_q);
    assign sh_load_data = (state_q == IDLE) ? {cmd_i.addr, cmd_i.rnw} : wdata_q;
    assign sh_shift = tick_i && scl_q && (state_q == ADDR || state_q == DATA);

    i3c_byte_shifter i_shifter (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .load_i      (sh_load),
        .load_data_i (sh_load_data),
        .shift_i     (sh_shift),
        .bit_i       (bus_i.sda),
        .bit_o       (sh_bit),
        .data_o      (sh_data)
    );

    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && cmd_i.start) begin
            wdata_q <= cmd_i.wdata;
        end
    end

    // SCL toggles on ticks, SDA moves one cycle after SCL falls
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q   <= IDLE;
            bit_cnt_q <= '0;
            fall_q    <= 1'b0;
            rnw_q     <= 1'b0;
            nack_q    <= 1'b0;
            done_q    <= 1'b0;
            sda_q     <= 1'b1;
            scl_q     <= 1'b1;
            rdata_q   <= '0;
        end else begin
            done_q <= 1'b0;
            fall_q <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (cmd_i.start) begin
                        rnw_q   <= cmd_i.rnw;
                        nack_q  <= 1'b0;
                        state_q <= START;
                    end
                end
                START: begin
                    if (tick_i && sda_q) begin
                        sda_q <= 1'b0;
                    end else if (tick_i) begin
                        scl_q     <= 1'b0;
                        fall_q    <= 1'b1;
                        bit_cnt_q <= '0;
                        state_q   <= ADDR;
                    end
                end
                ADDR, DATA: begin
                    // Read data is driven by the target
                    if (fall_q) begin
                        sda_q <= (state_q == DATA && rnw_q) ? 1'b1 : sh_bit;
                    end
                    if (tick_i) begin
                        scl_q <= !scl_q;
                        if (scl_q) begin
                            fall_q    <= 1'b1;
                            bit_cnt_q <= bit_cnt_q + 3'd1;
                            if (bit_cnt_q == 3'd7) begin
                                state_q <= (state_q == ADDR) ? ADDR_ACK : DATA_ACK;
                            end
                        end
                    end
                end
                ADDR_ACK: begin
                    if (fall_q) begin
                        sda_q <= 1'b1;
                    end
                    if (tick_i) begin
                        scl_q <= !scl_q;
                        if (scl_q) begin
                            fall_q  <= 1'b1;
                            nack_q  <= bus_i.sda;
                            state_q <= bus_i.sda ? STOP : DATA;
                        end
                    end
                end
                DATA_ACK: begin
                    // Released SDA is the NACK that ends a read
                    if (fall_q) begin
                        sda_q <= 1'b1;
                        if (rnw_q) begin
                            rdata_q <= sh_data;
                        end
                    end
                    if (tick_i) begin
                        scl_q <= !scl_q;
                        if (scl_q) begin
                            fall_q  <= 1'b1;
                            nack_q  <= !rnw_q && bus_i.sda;
                            state_q <= STOP;
                        end
                    end
                end
                STOP: begin
                    if (fall_q) begin
                        sda_q <= 1'b0;
                    end
                    if (tick_i && !scl_q) begin
                        scl_q <= 1'b1;
                    end else if (tick_i) begin
                        sda_q   <= 1'b1;
                        done_q  <= 1'b1;
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    assign timer_en_o = (state_q != IDLE);

    assign sts_o.busy  = (state_q != IDLE);
    assign sts_o.done  = done_q;
    assign sts_o.nack  = nack_q;
    assign sts_o.rdata = rdata_q;

    assign pins_o.sda = sda_q;
    assign pins_o.scl = scl_q;

    // Data moves only with SCL low, or START/STOP would appear on the bus
    a_sda_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (!($past(state_q) inside {START, STOP}) && $changed(pins_o.sda))
        |-> (!pins_o.scl && !$past(pins_o.scl)));

endmodule

//--- logic/i3c_target_regfile.sv
// One-byte register target at TargetAddr; needs two clk_i samples per SCL phase, never stretches
module i3c_target_regfile (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  i3c_pkg::od_pins_t bus_i,
    output i3c_pkg::od_pins_t pins_o
);

    typedef enum logic [2:0] {T_IDLE, T_ADDR, T_ADDR_ACK, T_WDATA, T_WACK, T_RDATA} tstate_e;

    tstate_e           state_q;
    i3c_pkg::od_pins_t s1_q;
    i3c_pkg::od_pins_t s2_q;
    logic [3:0]        cnt_q;
    logic              sda_q;
    logic              rnw_q;
    logic [7:0]        mem_q;
    logic              start_det;
    logic              stop_det;
    logic              scl_rise;
    logic              scl_fall;
    logic              store;
    logic              sh_load;
    logic              sh_shift;
    logic              sh_bit;
    logic [7:0]        sh_data;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            s1_q <= '1;
            s2_q <= '1;
        end else begin
            s1_q <= bus_i;
            s2_q <= s1_q;
        end
    end

    // START and STOP are SDA edges with SCL high in both samples
    assign start_det = s2_q.scl && s1_q.scl && s2_q.sda && !s1_q.sda;
    assign stop_det  = s2_q.scl && s1_q.scl && !s2_q.sda && s1_q.sda;
    assign scl_rise  = !s2_q.scl && s1_q.scl;
    assign scl_fall  = s2_q.scl && !s1_q.scl;

    assign store    = (state_q == T_WDATA) && scl_fall && (cnt_q == 4'd8);
    assign sh_load  = (state_q == T_ADDR_ACK) && scl_fall && rnw_q;
    assign sh_shift = ((state_q == T_ADDR || state_q == T_WDATA) && scl_rise)
                      || ((state_q == T_RDATA) && scl_fall);

    i3c_byte_shifter i_shifter (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .load_i      (sh_load),
        .load_data_i (mem_q),
        .shift_i     (sh_shift),
        .bit_i       (s1_q.sda),
        .bit_o       (sh_bit),
        .data_o      (sh_data)
    );

    always_ff @(posedge clk_i) begin
        if (store) begin
            mem_q <= sh_data;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= T_IDLE;
            cnt_q   <= '0;
            sda_q   <= 1'b1;
            rnw_q   <= 1'b0;
        end else if (start_det) begin
            state_q <= T_ADDR;
            cnt_q   <= '0;
            sda_q   <= 1'b1;
        end else if (stop_det) begin
            state_q <= T_IDLE;
            sda_q   <= 1'b1;
        end else begin
            case (state_q)
                T_ADDR, T_WDATA: begin
                    if (scl_rise) begin
                        cnt_q <= cnt_q + 4'd1;
                    end
                    if (scl_fall && cnt_q == 4'd8) begin
                        cnt_q <= '0;
                        if (state_q == T_WDATA) begin
                            sda_q   <= 1'b0;
                            state_q <= T_WACK;
                        end else if (sh_data[7:1] == i3c_pkg::TargetAddr) begin
                            sda_q   <= 1'b0;
                            rnw_q   <= sh_data[0];
                            state_q <= T_ADDR_ACK;
                        end else begin
                            // Not ours, stay off the bus until the next START
                            state_q <= T_IDLE;
                        end
                    end
                end
                T_ADDR_ACK: begin
                    if (scl_fall) begin
                        sda_q   <= 1'b1;
                        state_q <= rnw_q ? T_RDATA : T_WDATA;
                    end
                end
                T_WACK: begin
                    if (scl_fall) begin
                        sda_q   <= 1'b1;
                        state_q <= T_IDLE;
                    end
                end
                T_RDATA: begin
                    if (scl_fall) begin
                        cnt_q <= cnt_q + 4'd1;
                        if (cnt_q == 4'd7) begin
                            state_q <= T_IDLE;
                        end
                    end
                end
                default: state_q <= T_IDLE;
            endcase
        end
    end

    // Stored byte goes out MSB first while reading
    assign pins_o.sda = (state_q == T_RDATA) ? sh_bit : sda_q;
    assign pins_o.scl = 1'b1;

endmodule

//--- logic/i3c_test_wrapper.sv
// Top with APB controller, register target and external pins on one bus; external pins idle at 1
module i3c_test_wrapper (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  i3c_pkg::apb_req_t apb_req_i,
    output i3c_pkg::apb_rsp_t apb_rsp_o,
    input  logic              ext_sda_i,
    input  logic              ext_scl_i,
    output logic              bus_sda_o,
    output logic              bus_scl_o
);

    i3c_pkg::xfer_cmd_t cmd;
    i3c_pkg::xfer_sts_t sts;
    logic               tick;
    logic               timer_en;
    i3c_pkg::od_pins_t  bus;
    i3c_pkg::od_pins_t  dev_pins [i3c_pkg::NumBusDevices];

    i3c_apb_regs i_regs (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .apb_req_i (apb_req_i),
        .apb_rsp_o (apb_rsp_o),
        .cmd_o     (cmd),
        .sts_i     (sts)
    );

    i3c_bus_fsm i_fsm (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .cmd_i      (cmd),
        .sts_o      (sts),
        .tick_i     (tick),
        .timer_en_o (timer_en),
        .bus_i      (bus),
        .pins_o     (dev_pins[0])
    );

    i3c_scl_timer i_timer (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .en_i    (timer_en),
        .tick_o  (tick)
    );

    i3c_target_regfile i_target (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .bus_i   (bus),
        .pins_o  (dev_pins[1])
    );

    // Third device is an outside model
    assign dev_pins[2].sda = ext_sda_i;
    assign dev_pins[2].scl = ext_scl_i;

    i3c_bus_harness #(
        .NumDevices (i3c_pkg::NumBusDevices)
    ) i_harness (
        .dev_i (dev_pins),
        .bus_o (bus)
    );

    assign bus_sda_o = bus.sda;
    assign bus_scl_o = bus.scl;

endmodule

//--- tests/tb_i3c_checks.svh
// Compare tasks for the wrapper testbench; included into the testbench top, which supplies abort_run
`ifndef TB_I3C_CHECKS_SVH
`define TB_I3C_CHECKS_SVH

// Response data is only compared when with_data is set
task automatic check_apb_rsp(input string name, input i3c_pkg::apb_rsp_t exp,
                             input i3c_pkg::apb_rsp_t act, input bit with_data);
    if (act.pready !== exp.pready || act.pslverr !== exp.pslverr
            || (with_data && act.prdata !== exp.prdata)) begin
        abort_run($sformatf("FAIL %s expected %h actual %h", name, exp, act));
    end
endtask

task automatic check_status(input i3c_pkg::xfer_sts_t exp, input i3c_pkg::xfer_sts_t act);
    if (act !== exp) begin
        abort_run($sformatf("FAIL STATUS expected %h actual %h", exp, act));
    end
endtask

task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
        abort_run($sformatf("FAIL %s expected %h actual %h", name, exp, act));
    end
endtask

// Bus lines as one open-drain pair
task automatic check_bus(input i3c_pkg::od_pins_t exp, input i3c_pkg::od_pins_t act);
    if (act !== exp) begin
        abort_run($sformatf("FAIL bus_sda_o/bus_scl_o expected %h actual %h", exp, act));
    end
endtask

`endif

//--- tests/tb_i3c_test_wrapper.sv
// Runs from the project root to find its vector file; external bus pins stay released
module tb_i3c_test_wrapper;

    logic               clk;
    logic               rst_n;
    i3c_pkg::apb_req_t  apb_req;
    i3c_pkg::apb_rsp_t  apb_rsp;
    logic               ext_sda;
    logic               ext_scl;
    logic               bus_sda;
    logic               bus_scl;
    longint unsigned    cycle_cnt = 0;
    logic [7:0]         tx_model;
    logic [6:0]         ctrl_addr;
    logic               ctrl_rnw;
    i3c_pkg::apb_rsp_t  ok_rsp;
    i3c_pkg::apb_rsp_t  err_rsp;

    i3c_test_wrapper i_dut (
        .clk_i     (clk),
        .rst_n_i   (rst_n),
        .apb_req_i (apb_req),
        .apb_rsp_o (apb_rsp),
        .ext_sda_i (ext_sda),
        .ext_scl_i (ext_scl),
        .bus_sda_o (bus_sda),
        .bus_scl_o (bus_scl)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    `include "tb_i3c_checks.svh"

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1);
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Setup cycle, access cycle, response sampled mid access
    task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                              output i3c_pkg::apb_rsp_t rsp);
        i3c_pkg::apb_req_t req;
        req.psel    = 1'b1;
        req.penable = 1'b0;
        req.pwrite  = wr;
        req.paddr   = addr;
        req.pwdata  = wdata;
        @(posedge clk);
        apb_req <= req;
        req.penable = 1'b1;
        @(posedge clk);
        apb_req <= req;
        @(negedge clk);
        rsp = apb_rsp;
        @(posedge clk);
        apb_req <= '0;
    endtask

    // STATUS bit 0 busy, bit 1 done, bit 2 nack
    function automatic i3c_pkg::xfer_sts_t status_from(input logic [31:0] prdata);
        i3c_pkg::xfer_sts_t sts;
        sts.busy  = prdata[0];
        sts.done  = prdata[1];
        sts.nack  = prdata[2];
        sts.rdata = 8'h00;
        return sts;
    endfunction

    task automatic wait_done(output i3c_pkg::xfer_sts_t sts);
        i3c_pkg::apb_rsp_t rsp;
        longint unsigned   t0;
        t0 = cycle_cnt;
        sts = '0;
        while (!sts.done) begin
            apb_access(1'b0, i3c_pkg::RegStatus, 32'h0, rsp);
            check_apb_rsp("STATUS access", ok_rsp, rsp, 1'b0);
            sts = status_from(rsp.prdata);
            if (!sts.done && cycle_cnt - t0 >= 2000) begin
                abort_run("Timed out after 2000 cycles waiting for done in STATUS");
            end
        end
    endtask

    task automatic start_xfer(input logic rnw, input logic [6:0] addr, input logic [7:0] wdata);
        i3c_pkg::apb_rsp_t rsp;
        apb_access(1'b1, i3c_pkg::RegTx, {24'h0, wdata}, rsp);
        check_apb_rsp("TX write", ok_rsp, rsp, 1'b0);
        tx_model = wdata;
        apb_access(1'b1, i3c_pkg::RegCtrl, {23'h0, addr, rnw, 1'b1}, rsp);
        check_apb_rsp("CTRL write", ok_rsp, rsp, 1'b0);
        ctrl_addr = addr;
        ctrl_rnw  = rnw;
    endtask

    // Completion with the expected nack, then an idle bus
    task automatic finish_xfer(input logic exp_nack);
        i3c_pkg::xfer_sts_t sts;
        i3c_pkg::xfer_sts_t exp;
        i3c_pkg::od_pins_t  pins;
        wait_done(sts);
        exp.busy  = 1'b0;
        exp.done  = 1'b1;
        exp.nack  = exp_nack;
        exp.rdata = 8'h00;
        check_status(exp, sts);
        @(negedge clk);
        pins.sda = bus_sda;
        pins.scl = bus_scl;
        check_bus(2'b11, pins);
    endtask

    task automatic read_and_check(input logic [6:0] addr, input logic exp_nack,
                                  input logic [7:0] exp_data);
        i3c_pkg::apb_rsp_t rsp;
        start_xfer(1'b1, addr, tx_model);
        finish_xfer(exp_nack);
        if (!exp_nack) begin
            apb_access(1'b0, i3c_pkg::RegRx, 32'h0, rsp);
            check_apb_rsp("RX access", ok_rsp, rsp, 1'b0);
            check_byte("RX", exp_data, rsp.prdata[7:0]);
        end
    endtask

    // Unmapped offset is refused and leaves TX and CTRL as they were
    task automatic bad_offset(input logic [3:0] offs, input logic [7:0] wdata);
        i3c_pkg::apb_rsp_t rsp;
        i3c_pkg::apb_rsp_t exp;
        apb_access(1'b1, offs, {24'h0, wdata}, rsp);
        check_apb_rsp("pslverr on unmapped write", err_rsp, rsp, 1'b0);
        apb_access(1'b0, offs, 32'h0, rsp);
        check_apb_rsp("pslverr on unmapped read", err_rsp, rsp, 1'b0);
        exp = ok_rsp;
        exp.prdata = {24'h0, tx_model};
        apb_access(1'b0, i3c_pkg::RegTx, 32'h0, rsp);
        check_apb_rsp("TX readback", exp, rsp, 1'b1);
        exp.prdata = {23'h0, ctrl_addr, ctrl_rnw, 1'b0};
        apb_access(1'b0, i3c_pkg::RegCtrl, 32'h0, rsp);
        check_apb_rsp("CTRL readback", exp, rsp, 1'b1);
    endtask

    task automatic busy_start(input logic [6:0] addr, input logic [7:0] wdata,
                              input logic exp_nack);
        i3c_pkg::apb_rsp_t rsp;
        start_xfer(1'b0, addr, wdata);
        apb_access(1'b1, i3c_pkg::RegCtrl, {23'h0, addr, 1'b1, 1'b1}, rsp);
        check_apb_rsp("pslverr on START while busy", err_rsp, rsp, 1'b0);
        finish_xfer(exp_nack);
    endtask

    initial begin
        int                 fd;
        int                 n;
        string              line;
        string              op;
        logic [31:0]        a;
        logic [31:0]        d;
        logic [31:0]        en;
        logic [31:0]        ed;
        logic [31:0]        rng;
        logic [7:0]         rbyte;
        i3c_pkg::apb_rsp_t  rsp;
        i3c_pkg::od_pins_t  pins;

        ok_rsp   = '0;
        ok_rsp.pready = 1'b1;
        err_rsp  = ok_rsp;
        err_rsp.pslverr = 1'b1;
        tx_model  = 8'h00;
        ctrl_addr = 7'h00;
        ctrl_rnw  = 1'b0;
        rst_n   = 1'b0;
        apb_req = '0;
        ext_sda = 1'b1;
        ext_scl = 1'b1;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        @(negedge clk);
        pins.sda = bus_sda;
        pins.scl = bus_scl;
        check_bus(2'b11, pins);
        apb_access(1'b0, i3c_pkg::RegStatus, 32'h0, rsp);
        check_apb_rsp("STATUS after reset", ok_rsp, rsp, 1'b1);

        fd = $fopen("tests/i3c_input_vectors.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open tests/i3c_input_vectors.txt");
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n <= 1 || line.substr(0, 0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%s %h %h %h %h", op, a, d, en, ed);
            if (n != 5) begin
                abort_run($sformatf("Malformed vector line: %s", line));
            end
            if (op == "write") begin
                start_xfer(1'b0, a[6:0], d[7:0]);
                finish_xfer(en[0]);
            end else if (op == "read") begin
                read_and_check(a[6:0], en[0], ed[7:0]);
            end else if (op == "badoff") begin
                bad_offset(a[3:0], d[7:0]);
            end else if (op == "busy") begin
                busy_start(a[6:0], d[7:0], en[0]);
            end else begin
                abort_run($sformatf("Unknown operation in vector file: %s", op));
            end
        end
        $fclose(fd);

        // Random write and readback rounds
        rng = 32'd96161;
        repeat (8) begin
            rng   = xorshift32(rng);
            rbyte = rng[7:0];
            start_xfer(1'b0, i3c_pkg::TargetAddr, rbyte);
            finish_xfer(1'b0);
            read_and_check(i3c_pkg::TargetAddr, 1'b0, rbyte);
        end

        $display("All checks passed");
        $finish;
    end

endmodule

//--- project.f
+incdir+tests
logic/i3c_pkg.sv
logic/i3c_byte_shifter.sv
logic/i3c_scl_timer.sv
logic/i3c_bus_harness.sv
logic/i3c_apb_regs.sv
logic/i3c_bus_fsm.sv
logic/i3c_target_regfile.sv
logic/i3c_test_wrapper.sv
tests/tb_i3c_test_wrapper.sv

//--- tests/i3c_input_vectors.txt
# op addr data exp_nack exp_rdata, all fields after op in hex
# ops are write, read, badoff (addr is the APB offset) and busy (START while busy)
write 2a 5a 0 00
read 2a 00 0 5a
write 2a c3 0 00
read 2a 00 0 c3
write 15 77 1 00
read 2a 00 0 c3
read 55 00 1 00
read 2a 00 0 c3
badoff 2 99 0 00
badoff 6 11 0 00
busy 2a 3c 0 00
read 2a 00 0 3c
busy 31 e1 1 00
read 2a 00 0 3c
write 2a 00 0 00
read 2a 00 0 00
write 2a ff 0 00
read 2a 00 0 ff
